// ==== include/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// bank geometry
`define CACHE_WORD_BYTES      4
`define CACHE_WORDS_PER_LINE  4
`define CACHE_NUM_SETS        16
`define CACHE_LINE_ADDR_BITS  12
`define CACHE_CORE_TAG_BITS   8

// derived widths
`define CACHE_WORD_BITS       (8 * `CACHE_WORD_BYTES)
`define CACHE_LINE_BYTES      (`CACHE_WORD_BYTES * `CACHE_WORDS_PER_LINE)
`define CACHE_LINE_BITS       (8 * `CACHE_LINE_BYTES)
`define CACHE_WSEL_BITS       $clog2(`CACHE_WORDS_PER_LINE)
`define CACHE_SET_BITS        $clog2(`CACHE_NUM_SETS)
`define CACHE_LINE_TAG_BITS   (`CACHE_LINE_ADDR_BITS - `CACHE_SET_BITS)

// queue depths
`define CACHE_CREQ_DEPTH      4
`define CACHE_CRSQ_DEPTH      4
`define CACHE_DREQ_DEPTH      4

`endif

// ==== hw/cache_mem_pkg.sv ====
`default_nettype none

`include "cache_cfg.svh"

package cache_mem_pkg;

    typedef logic [`CACHE_LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [`CACHE_SET_BITS-1:0]       set_idx_t;
    typedef logic [`CACHE_LINE_TAG_BITS-1:0]  line_tag_t;
    typedef logic [`CACHE_LINE_BITS-1:0]      line_t;
    typedef logic [`CACHE_LINE_BYTES-1:0]     line_byteen_t;

    typedef struct packed {
        logic         rw;
        line_byteen_t byteen;
        line_addr_t   addr;
        line_t        data;
    } dram_req_t;

    // low bits pick the set, the rest is the tag
    function automatic set_idx_t set_of(line_addr_t addr);
        return addr[`CACHE_SET_BITS-1:0];
    endfunction

    function automatic line_tag_t tag_of(line_addr_t addr);
        return addr[`CACHE_LINE_ADDR_BITS-1:`CACHE_SET_BITS];
    endfunction

endpackage

`default_nettype wire

// ==== hw/cache_core_pkg.sv ====
`default_nettype none

`include "cache_cfg.svh"

package cache_core_pkg;

    typedef logic [`CACHE_WORD_BITS-1:0]     word_t;
    typedef logic [`CACHE_WSEL_BITS-1:0]     word_sel_t;
    typedef logic [`CACHE_WORD_BYTES-1:0]    word_byteen_t;
    typedef logic [`CACHE_CORE_TAG_BITS-1:0] core_tag_t;

    typedef struct packed {
        logic                     rw;
        cache_mem_pkg::line_addr_t addr;
        word_sel_t                wsel;
        word_byteen_t             byteen;
        word_t                    data;
        core_tag_t                tag;
    } core_req_t;

    // tag is echoed back unchanged
    typedef struct packed {
        word_t     data;
        core_tag_t tag;
    } core_rsp_t;

endpackage

`default_nettype wire

// ==== hw/cache_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     push,
    input  wire logic     pop,
    input  wire payload_t data_in,
    output payload_t      data_out,
    output logic          empty,
    output logic          full,
    output logic          alm_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= data_in;
    end

    assign data_out = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    // two free entries or fewer
    assign alm_full = (count >= CNT_W'(DEPTH - 2));

endmodule

`default_nettype wire

// ==== hw/cache_tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_tag_store (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire cache_mem_pkg::line_addr_t lookup_addr,
    input  wire logic                      fill,
    output logic                           hit
);

    import cache_mem_pkg::*;

    logic [`CACHE_NUM_SETS-1:0] valid;
    line_tag_t                  tags [`CACHE_NUM_SETS];
    set_idx_t                   set_idx;
    line_tag_t                  lookup_tag;

    assign set_idx    = set_of(lookup_addr);
    assign lookup_tag = tag_of(lookup_addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (fill) begin
            valid[set_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill)
            tags[set_idx] <= lookup_tag;
    end

    // combinational compare in stage 0
    assign hit = valid[set_idx] && (tags[set_idx] == lookup_tag);

endmodule

`default_nettype wire

// ==== hw/cache_data_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_data_store (
    input  wire logic                        clk,
    input  wire cache_mem_pkg::line_addr_t   addr,
    input  wire logic                        write,
    input  wire cache_mem_pkg::line_byteen_t byteen,
    input  wire cache_mem_pkg::line_t        wdata,
    output cache_mem_pkg::line_t             rdata
);

    import cache_mem_pkg::*;

    line_t    lines [`CACHE_NUM_SETS];
    set_idx_t set_idx;
    line_t    merged;

    assign set_idx = set_of(addr);

    // keep old bytes where the enable is low
    always_comb begin
        merged = lines[set_idx];
        for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
            if (byteen[b])
                merged[b*8 +: 8] = wdata[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (write)
            lines[set_idx] <= merged;
    end

    // whole line read in stage 1
    assign rdata = lines[set_idx];

endmodule

`default_nettype wire

// ==== hw/cache_bank_sched.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_bank_sched (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      creq_valid,
    input  wire cache_core_pkg::core_req_t creq,
    output logic                           creq_pop,
    input  wire logic                      dram_rsp_valid,
    output logic                           dram_rsp_ready,
    input  wire logic                      crsq_alm_full,
    input  wire logic                      dreq_alm_full,
    input  wire logic                      st0_read,
    input  wire logic                      st1_read,
    input  wire logic                      st1_fill_done,
    input  wire logic                      miss_park,
    input  wire cache_core_pkg::core_req_t miss_req,
    output logic                           issue_valid,
    output logic                           issue_fill,
    output cache_core_pkg::core_req_t      issue_req
);

    import cache_core_pkg::*;

    logic      slot_valid;
    logic      slot_fill_sent;
    logic      slot_filled;
    core_req_t slot_req;
    logic      fill_sel;
    logic      replay_sel;
    logic      core_sel;

    // accept the line once, while the parked read still waits for it
    assign dram_rsp_ready = slot_valid && !slot_fill_sent;

    assign fill_sel   = dram_rsp_valid && dram_rsp_ready;
    assign replay_sel = !fill_sel && slot_valid && slot_filled;
    assign core_sel   = !fill_sel && !replay_sel && creq_valid && !slot_valid
                     && !st0_read && !st1_read && !crsq_alm_full && !dreq_alm_full;

    assign creq_pop    = core_sel;
    assign issue_valid = fill_sel || replay_sel || core_sel;
    assign issue_fill  = fill_sel;
    // fill and replay both carry the parked read's address
    assign issue_req   = slot_valid ? slot_req : creq;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid     <= 1'b0;
            slot_fill_sent <= 1'b0;
            slot_filled    <= 1'b0;
        end else if (miss_park) begin
            slot_valid     <= 1'b1;
            slot_fill_sent <= 1'b0;
            slot_filled    <= 1'b0;
        end else if (replay_sel) begin
            slot_valid     <= 1'b0;
            slot_fill_sent <= 1'b0;
            slot_filled    <= 1'b0;
        end else begin
            if (fill_sel)
                slot_fill_sent <= 1'b1;
            // line is installed once the fill leaves stage 1
            if (st1_fill_done)
                slot_filled <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (miss_park)
            slot_req <= miss_req;
    end

endmodule

`default_nettype wire

// ==== hw/cache_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_bank (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         core_req_valid,
    input  wire logic                         core_req_rw,
    input  wire cache_mem_pkg::line_addr_t    core_req_addr,
    input  wire cache_core_pkg::word_sel_t    core_req_wsel,
    input  wire cache_core_pkg::word_byteen_t core_req_byteen,
    input  wire cache_core_pkg::word_t        core_req_data,
    input  wire cache_core_pkg::core_tag_t    core_req_tag,
    output logic                              core_req_ready,
    output logic                              core_rsp_valid,
    output cache_core_pkg::word_t             core_rsp_data,
    output cache_core_pkg::core_tag_t         core_rsp_tag,
    input  wire logic                         core_rsp_ready,
    output logic                              dram_req_valid,
    output logic                              dram_req_rw,
    output cache_mem_pkg::line_byteen_t       dram_req_byteen,
    output cache_mem_pkg::line_addr_t         dram_req_addr,
    output cache_mem_pkg::line_t              dram_req_data,
    input  wire logic                         dram_req_ready,
    input  wire logic                         dram_rsp_valid,
    input  wire cache_mem_pkg::line_t         dram_rsp_data,
    output logic                              dram_rsp_ready
);

    import cache_mem_pkg::*;
    import cache_core_pkg::*;

    localparam int WORD_BITS = $bits(word_t);

    core_req_t    creq_in;
    core_req_t    creq_out;
    logic         creq_full;
    logic         creq_empty;
    logic         creq_pop;
    core_rsp_t    crsq_in;
    core_rsp_t    crsq_out;
    logic         crsq_push;
    logic         crsq_empty;
    logic         crsq_alm_full;
    dram_req_t    dreq_in;
    dram_req_t    dreq_out;
    logic         dreq_push;
    logic         dreq_empty;
    logic         dreq_alm_full;
    logic         issue_valid;
    logic         issue_fill;
    core_req_t    issue_req;
    logic         st0_valid;
    logic         st0_fill;
    logic         st0_hit;
    core_req_t    st0_req;
    line_t        st0_data;
    logic         st1_valid;
    logic         st1_fill;
    logic         st1_hit;
    core_req_t    st1_req;
    line_t        st1_data;
    line_t        st1_rdata;
    logic         st1_core;
    logic         st1_rd_hit;
    logic         st1_rd_miss;
    logic         st1_wr;
    logic         st1_fill_done;
    line_byteen_t st1_line_byteen;

    assign creq_in = '{rw: core_req_rw, addr: core_req_addr, wsel: core_req_wsel,
                       byteen: core_req_byteen, data: core_req_data, tag: core_req_tag};
    assign core_req_ready = !creq_full;

    cache_fifo #(.payload_t(core_req_t), .DEPTH(`CACHE_CREQ_DEPTH)) core_req_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (core_req_valid && core_req_ready),
        .pop      (creq_pop),
        .data_in  (creq_in),
        .data_out (creq_out),
        .empty    (creq_empty),
        .full     (creq_full),
        .alm_full ()
    );

    cache_bank_sched sched (
        .clk            (clk),
        .rst_n          (rst_n),
        .creq_valid     (!creq_empty),
        .creq           (creq_out),
        .creq_pop       (creq_pop),
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp_ready (dram_rsp_ready),
        .crsq_alm_full  (crsq_alm_full),
        .dreq_alm_full  (dreq_alm_full),
        .st0_read       (st0_valid && !st0_fill && !st0_req.rw),
        .st1_read       (st1_valid && !st1_fill && !st1_req.rw),
        .st1_fill_done  (st1_fill_done),
        .miss_park      (st1_rd_miss),
        .miss_req       (st1_req),
        .issue_valid    (issue_valid),
        .issue_fill     (issue_fill),
        .issue_req      (issue_req)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st0_valid <= 1'b0;
            st0_fill  <= 1'b0;
            st1_valid <= 1'b0;
            st1_fill  <= 1'b0;
        end else begin
            st0_valid <= issue_valid;
            st0_fill  <= issue_valid && issue_fill;
            st1_valid <= st0_valid;
            st1_fill  <= st0_fill;
        end
    end

    // fill line or the core word copied across the line
    always_ff @(posedge clk) begin
        st0_req  <= issue_req;
        st0_data <= issue_fill ? dram_rsp_data : {`CACHE_WORDS_PER_LINE{issue_req.data}};
        st1_req  <= st0_req;
        st1_data <= st0_data;
        st1_hit  <= st0_hit;
    end

    cache_tag_store tag_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_addr (st0_req.addr),
        .fill        (st0_valid && st0_fill),
        .hit         (st0_hit)
    );

    assign st1_core      = st1_valid && !st1_fill;
    assign st1_rd_hit    = st1_core && !st1_req.rw && st1_hit;
    assign st1_rd_miss   = st1_core && !st1_req.rw && !st1_hit;
    assign st1_wr        = st1_core && st1_req.rw;
    assign st1_fill_done = st1_valid && st1_fill;

    always_comb begin
        st1_line_byteen = '0;
        st1_line_byteen[st1_req.wsel*`CACHE_WORD_BYTES +: `CACHE_WORD_BYTES] = st1_req.byteen;
    end

    cache_data_store data_store (
        .clk    (clk),
        .addr   (st1_req.addr),
        .write  (st1_fill_done || (st1_wr && st1_hit)),
        .byteen (st1_fill ? {`CACHE_LINE_BYTES{1'b1}} : st1_line_byteen),
        .wdata  (st1_data),
        .rdata  (st1_rdata)
    );

    assign crsq_push = st1_rd_hit;
    assign crsq_in   = '{data: st1_rdata[st1_req.wsel*WORD_BITS +: WORD_BITS], tag: st1_req.tag};

    cache_fifo #(.payload_t(core_rsp_t), .DEPTH(`CACHE_CRSQ_DEPTH)) core_rsp_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (crsq_push),
        .pop      (core_rsp_valid && core_rsp_ready),
        .data_in  (crsq_in),
        .data_out (crsq_out),
        .empty    (crsq_empty),
        .full     (),
        .alm_full (crsq_alm_full)
    );

    assign core_rsp_valid = !crsq_empty;
    assign core_rsp_data  = crsq_out.data;
    assign core_rsp_tag   = crsq_out.tag;

    // write-through on every write, fill request on a read miss
    assign dreq_push = st1_rd_miss || st1_wr;
    assign dreq_in   = '{rw: st1_wr,
                         byteen: st1_wr ? st1_line_byteen : {`CACHE_LINE_BYTES{1'b1}},
                         addr: st1_req.addr, data: st1_data};

    cache_fifo #(.payload_t(dram_req_t), .DEPTH(`CACHE_DREQ_DEPTH)) dram_req_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (dreq_push),
        .pop      (dram_req_valid && dram_req_ready),
        .data_in  (dreq_in),
        .data_out (dreq_out),
        .empty    (dreq_empty),
        .full     (),
        .alm_full (dreq_alm_full)
    );

    assign dram_req_valid  = !dreq_empty;
    assign dram_req_rw     = dreq_out.rw;
    assign dram_req_byteen = dreq_out.byteen;
    assign dram_req_addr   = dreq_out.addr;
    assign dram_req_data   = dreq_out.data;

endmodule

`default_nettype wire

// ==== bench/cache_bank_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_bank_sva (
    input wire logic                        clk,
    input wire logic                        rst_n,
    input wire logic                        core_rsp_valid,
    input wire logic                        core_rsp_ready,
    input wire cache_core_pkg::word_t       core_rsp_data,
    input wire cache_core_pkg::core_tag_t   core_rsp_tag,
    input wire logic                        dram_req_valid,
    input wire logic                        dram_req_ready,
    input wire logic                        dram_req_rw,
    input wire cache_mem_pkg::line_byteen_t dram_req_byteen,
    input wire cache_mem_pkg::line_addr_t   dram_req_addr,
    input wire cache_mem_pkg::line_t        dram_req_data
);

    // response held while the core stalls
    rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        core_rsp_valid && !core_rsp_ready
        |=> core_rsp_valid && $stable({core_rsp_data, core_rsp_tag}))
        else $error("core response changed while stalled");

    // DRAM request held while DRAM stalls
    dreq_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dram_req_valid && !dram_req_ready
        |=> dram_req_valid
            && $stable({dram_req_rw, dram_req_byteen, dram_req_addr, dram_req_data}))
        else $error("DRAM request changed while stalled");

endmodule

bind cache_bank cache_bank_sva sva_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .core_rsp_valid  (core_rsp_valid),
    .core_rsp_ready  (core_rsp_ready),
    .core_rsp_data   (core_rsp_data),
    .core_rsp_tag    (core_rsp_tag),
    .dram_req_valid  (dram_req_valid),
    .dram_req_ready  (dram_req_ready),
    .dram_req_rw     (dram_req_rw),
    .dram_req_byteen (dram_req_byteen),
    .dram_req_addr   (dram_req_addr),
    .dram_req_data   (dram_req_data)
);

`default_nettype wire

// ==== bench/cache_bank_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_bank_tb;

    import cache_mem_pkg::*;
    import cache_core_pkg::*;

    localparam int         CLK_HALF     = 50;
    localparam int         DRIVE_DELAY  = 1;
    localparam int         RESET_CYCLES = 16;
    localparam int         FILL_DELAY   = 3;
    localparam int         RANDOM_OPS   = 200;
    localparam int         WORD_BITS    = $bits(word_t);
    localparam logic[31:0] RANDOM_SEED  = 32'hec965253;
    // directed tests stay well under 400 cycles and a random miss costs about 15
    localparam int         TIMEOUT_CYCLES = RESET_CYCLES + 400 + RANDOM_OPS * 15;
    localparam line_addr_t ADDR_A = 12'h123;
    localparam line_addr_t ADDR_B = 12'h2a7;

    logic         clk;
    logic         rst_n;
    logic         core_req_valid;
    logic         core_req_rw;
    line_addr_t   core_req_addr;
    word_sel_t    core_req_wsel;
    word_byteen_t core_req_byteen;
    word_t        core_req_data;
    core_tag_t    core_req_tag;
    logic         core_req_ready;
    logic         core_rsp_valid;
    word_t        core_rsp_data;
    core_tag_t    core_rsp_tag;
    logic         core_rsp_ready;
    logic         dram_req_valid;
    logic         dram_req_rw;
    line_byteen_t dram_req_byteen;
    line_addr_t   dram_req_addr;
    line_t        dram_req_data;
    logic         dram_req_ready;
    logic         dram_rsp_valid = 1'b0;
    line_t        dram_rsp_data = '0;
    logic         dram_rsp_ready;

    // DRAM contents as the model sees them, and the expected contents
    line_t        dram_mem [line_addr_t];
    line_t        ref_mem [line_addr_t];
    dram_req_t    dreq_log [$];
    core_rsp_t    rsp_q [$];
    core_rsp_t    exp_q [$];
    core_rsp_t    mon_rsp;
    dram_req_t    mon_req;
    line_addr_t   fill_addr;
    int           fill_wait = 0;
    logic         fill_taken = 1'b0;
    int           stall_cycles = 0;
    int           cycle_count = 0;

    cache_bank cache_bank_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .core_req_valid  (core_req_valid),
        .core_req_rw     (core_req_rw),
        .core_req_addr   (core_req_addr),
        .core_req_wsel   (core_req_wsel),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .core_req_ready  (core_req_ready),
        .core_rsp_valid  (core_rsp_valid),
        .core_rsp_data   (core_rsp_data),
        .core_rsp_tag    (core_rsp_tag),
        .core_rsp_ready  (core_rsp_ready),
        .dram_req_valid  (dram_req_valid),
        .dram_req_rw     (dram_req_rw),
        .dram_req_byteen (dram_req_byteen),
        .dram_req_addr   (dram_req_addr),
        .dram_req_data   (dram_req_data),
        .dram_req_ready  (dram_req_ready),
        .dram_rsp_valid  (dram_rsp_valid),
        .dram_rsp_data   (dram_rsp_data),
        .dram_rsp_ready  (dram_rsp_ready)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run($sformatf("timeout, run still busy after %0d cycles", cycle_count));
    end

    // untouched lines hold a pattern built from the whole line address
    function automatic line_t init_line(line_addr_t addr);
        line_t line;
        for (int w = 0; w < `CACHE_WORDS_PER_LINE; w++)
            line[w*WORD_BITS +: WORD_BITS] = {8'(8'hd0 + w), 4'h0, addr, addr[7:0] ^ 8'h3c};
        return line;
    endfunction

    function automatic line_t apply_bytes(line_t line, line_byteen_t be, line_t data);
        line_t result;
        result = line;
        for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
            if (be[b])
                result[b*8 +: 8] = data[b*8 +: 8];
        end
        return result;
    endfunction

    function automatic line_byteen_t lane_byteen(word_sel_t wsel, word_byteen_t be);
        return line_byteen_t'(be) << (int'(wsel) * `CACHE_WORD_BYTES);
    endfunction

    task automatic abort_run(input string reason);
        $display("ERROR: %s", reason);
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            abort_run($sformatf("%s mismatch", name));
        end
    endtask

    // DRAM model and output monitors sample at the falling edge
    always begin
        @(negedge clk);
        if (rst_n) begin
            if (core_req_valid && !core_req_ready)
                stall_cycles++;
            if (core_rsp_valid && core_rsp_ready) begin
                mon_rsp.data = core_rsp_data;
                mon_rsp.tag  = core_rsp_tag;
                rsp_q.push_back(mon_rsp);
            end
            if (dram_rsp_valid && dram_rsp_ready)
                fill_taken = 1'b1;
            if (dram_req_valid && dram_req_ready) begin
                mon_req.rw     = dram_req_rw;
                mon_req.byteen = dram_req_byteen;
                mon_req.addr   = dram_req_addr;
                mon_req.data   = dram_req_data;
                dreq_log.push_back(mon_req);
                if (!dram_mem.exists(dram_req_addr))
                    dram_mem[dram_req_addr] = init_line(dram_req_addr);
                if (dram_req_rw) begin
                    dram_mem[dram_req_addr] = apply_bytes(dram_mem[dram_req_addr],
                                                          dram_req_byteen, dram_req_data);
                end else if (fill_wait > 0 || dram_rsp_valid) begin
                    abort_run("DRAM got a second fill request while one was outstanding");
                end else begin
                    fill_addr = dram_req_addr;
                    fill_wait = FILL_DELAY;
                end
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
        if (fill_taken) begin
            dram_rsp_valid = 1'b0;
            fill_taken     = 1'b0;
        end
        if (fill_wait > 0) begin
            fill_wait--;
            if (fill_wait == 0) begin
                dram_rsp_valid = 1'b1;
                dram_rsp_data  = dram_mem[fill_addr];
            end
        end
    end

    // called just after a rising edge and returns just after the edge of the transfer
    task automatic send_request(input logic rw, input line_addr_t addr, input word_sel_t wsel,
                                input word_byteen_t be, input word_t data,
                                input core_tag_t tag);
        line_t     cur;
        core_rsp_t exp;
        if (!ref_mem.exists(addr))
            ref_mem[addr] = init_line(addr);
        cur = ref_mem[addr];
        if (rw) begin
            ref_mem[addr] = apply_bytes(cur, lane_byteen(wsel, be),
                                        {`CACHE_WORDS_PER_LINE{data}});
        end else begin
            exp.data = cur[int'(wsel)*WORD_BITS +: WORD_BITS];
            exp.tag  = tag;
            exp_q.push_back(exp);
        end
        core_req_valid  = 1'b1;
        core_req_rw     = rw;
        core_req_addr   = addr;
        core_req_wsel   = wsel;
        core_req_byteen = be;
        core_req_data   = data;
        core_req_tag    = tag;
        @(negedge clk);
        while (!core_req_ready)
            @(negedge clk);
        @(posedge clk);
        #DRIVE_DELAY;
        core_req_valid = 1'b0;
    endtask

    task automatic settle(input int cycles);
        repeat (cycles) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic wait_dram_reqs(input int count);
        while (dreq_log.size() < count)
            @(negedge clk);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic compare_responses();
        core_rsp_t got;
        core_rsp_t exp;
        while (rsp_q.size() < exp_q.size())
            @(negedge clk);
        @(posedge clk);
        #DRIVE_DELAY;
        while (exp_q.size() > 0) begin
            got = rsp_q.pop_front();
            exp = exp_q.pop_front();
            check_value("core_rsp_tag", 128'(got.tag), 128'(exp.tag));
            check_value("core_rsp_data", 128'(got.data), 128'(exp.data));
        end
        settle(4);
        check_value("core_rsp_count", 128'(rsp_q.size()), 128'd0);
    endtask

    task automatic check_dram_req(input logic rw, input line_byteen_t be,
                                  input line_addr_t addr, input line_t data);
        dram_req_t got;
        got = dreq_log.pop_front();
        check_value("dram_req_rw", 128'(got.rw), 128'(rw));
        check_value("dram_req_byteen", 128'(got.byteen), 128'(be));
        check_value("dram_req_addr", 128'(got.addr), 128'(addr));
        // fill requests carry no data
        if (rw)
            check_value("dram_req_data", got.data, data);
    endtask

    task automatic test_read_miss();
        dreq_log.delete();
        send_request(1'b0, ADDR_A, 2'd2, 4'hf, 32'h0, 8'h11);
        wait_dram_reqs(1);
        check_dram_req(1'b0, '1, ADDR_A, '0);
        compare_responses();
        check_value("dram_req_count", 128'(dreq_log.size()), 128'd0);
    endtask

    task automatic test_read_hit();
        dreq_log.delete();
        send_request(1'b0, ADDR_A, 2'd1, 4'hf, 32'h0, 8'h22);
        compare_responses();
        check_value("dram_req_count", 128'(dreq_log.size()), 128'd0);
    endtask

    task automatic test_write_hit();
        dreq_log.delete();
        send_request(1'b1, ADDR_A, 2'd3, 4'b0101, 32'hcafe_f00d, 8'h33);
        wait_dram_reqs(1);
        check_dram_req(1'b1, lane_byteen(2'd3, 4'b0101), ADDR_A, {4{32'hcafe_f00d}});
        send_request(1'b0, ADDR_A, 2'd3, 4'hf, 32'h0, 8'h34);
        compare_responses();
        check_value("dram_req_count", 128'(dreq_log.size()), 128'd0);
    endtask

    task automatic test_write_miss();
        dreq_log.delete();
        send_request(1'b1, ADDR_B, 2'd0, 4'b1110, 32'h1234_5678, 8'h44);
        wait_dram_reqs(1);
        check_dram_req(1'b1, lane_byteen(2'd0, 4'b1110), ADDR_B, {4{32'h1234_5678}});
        settle(4);
        check_value("dram_req_count", 128'(dreq_log.size()), 128'd0);
        send_request(1'b0, ADDR_B, 2'd0, 4'hf, 32'h0, 8'h45);
        wait_dram_reqs(1);
        check_dram_req(1'b0, '1, ADDR_B, '0);
        compare_responses();
    endtask

    task automatic test_back_pressure();
        int stalls_before;
        dreq_log.delete();
        stalls_before  = stall_cycles;
        core_rsp_ready = 1'b0;
        dram_req_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < 12; i++) begin
                    if (i % 2 == 0)
                        send_request(1'b1, (i % 4 == 0) ? ADDR_A : line_addr_t'(12'h300 + i),
                                     word_sel_t'(i), 4'hf, 32'h5a5a_0000 + i, core_tag_t'(8'h80 + i));
                    else
                        send_request(1'b0, ADDR_A, word_sel_t'(i), 4'hf, 32'h0,
                                     core_tag_t'(8'h80 + i));
                end
            end
            begin
                while (stall_cycles == stalls_before)
                    @(negedge clk);
                @(posedge clk);
                #DRIVE_DELAY;
                core_rsp_ready = 1'b1;
                dram_req_ready = 1'b1;
            end
        join
        compare_responses();
        wait_dram_reqs(6);
        // writes leave in issue order
        for (int i = 0; i < 12; i += 2)
            check_dram_req(1'b1, lane_byteen(word_sel_t'(i), 4'hf),
                           (i % 4 == 0) ? ADDR_A : line_addr_t'(12'h300 + i),
                           {`CACHE_WORDS_PER_LINE{32'h5a5a_0000 + i}});
        check_value("dram_req_count", 128'(dreq_log.size()), 128'd0);
    endtask

    task automatic test_random_mix();
        line_addr_t addr;
        logic       rw;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            addr = line_addr_t'(12'h400 + $urandom_range(0, 31));
            rw   = 1'($urandom_range(0, 1));
            send_request(rw, addr, word_sel_t'($urandom_range(0, 3)),
                         word_byteen_t'($urandom_range(0, 15)), $urandom, core_tag_t'(n));
        end
        compare_responses();
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        core_req_valid  = 1'b0;
        core_req_rw     = 1'b0;
        core_req_addr   = '0;
        core_req_wsel   = '0;
        core_req_byteen = '0;
        core_req_data   = '0;
        core_req_tag    = '0;
        core_rsp_ready  = 1'b1;
        dram_req_ready  = 1'b1;
        void'($urandom(RANDOM_SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        check_value("core_req_ready", 128'(core_req_ready), 128'd1);
        check_value("core_rsp_valid", 128'(core_rsp_valid), 128'd0);
        check_value("dram_req_valid", 128'(dram_req_valid), 128'd0);
        check_value("dram_rsp_ready", 128'(dram_rsp_ready), 128'd0);
        test_read_miss();
        test_read_hit();
        test_write_hit();
        test_write_miss();
        test_back_pressure();
        test_random_mix();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
hw/cache_mem_pkg.sv
hw/cache_core_pkg.sv
hw/cache_fifo.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/cache_bank_sched.sv
hw/cache_bank.sv
bench/cache_bank_sva.sv
bench/cache_bank_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   := tb.f
TB_TOP     := cache_bank_tb
RTL_TOP    := cache_bank
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Testbench passed
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
